/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - files:
      - eeprom_pkg.sv
      - i2c_bit_engine.sv
      - eeprom_sequencer.sv
      - request_arbiter.sv
      - eeprom_ctrl_top.sv
  - target: test
    files:
      - eeprom_model.sv
      - tb_eeprom_ctrl.sv

/* compile.f */
eeprom_pkg.sv
i2c_bit_engine.sv
eeprom_sequencer.sv
request_arbiter.sv
eeprom_ctrl_top.sv
eeprom_model.sv
tb_eeprom_ctrl.sv

/* eeprom_ctrl_top.sv */
`default_nettype none

module eeprom_ctrl_top #(
    parameter int CLK_DIV     = 4,   // clocks per quarter scl period
    parameter int NUM_CLIENTS = 2
) (
    input  logic                                       CLK,
    input  logic                                       RESET,
    input  logic [NUM_CLIENTS-1:0]                     req_valid,
    output logic [NUM_CLIENTS-1:0]                     req_ready,
    input  eeprom_pkg::eeprom_req_t [NUM_CLIENTS-1:0]  req,
    output logic [NUM_CLIENTS-1:0]                     rsp_valid,
    output eeprom_pkg::eeprom_rsp_t [NUM_CLIENTS-1:0]  rsp,
    output logic                                       scl,
    output logic                                       sda_drive_low,
    input  logic                                       sda_in
);
    import eeprom_pkg::*;

    logic        grant_valid;
    logic        grant_ready;
    eeprom_req_t grant_req;
    logic        done;
    eeprom_rsp_t done_rsp;
    logic        cmd_valid;
    logic        cmd_ready;
    bit_cmd_t    cmd;
    logic        res_valid;
    bit_rsp_t    res;

    request_arbiter #(
        .NUM_CLIENTS (NUM_CLIENTS)
    ) u_arbiter (
        .CLK         (CLK),
        .RESET       (RESET),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .grant_valid (grant_valid),
        .grant_ready (grant_ready),
        .grant_req   (grant_req),
        .done        (done),
        .done_rsp    (done_rsp)
    );

    eeprom_sequencer u_sequencer (
        .CLK         (CLK),
        .RESET       (RESET),
        .grant_valid (grant_valid),
        .grant_ready (grant_ready),
        .grant_req   (grant_req),
        .done        (done),
        .done_rsp    (done_rsp),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd         (cmd),
        .res_valid   (res_valid),
        .res         (res)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd           (cmd),
        .res_valid     (res_valid),
        .res           (res),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

`default_nettype wire

/* eeprom_model.sv */
`default_nettype none

module eeprom_model (
    input  wire scl,
    inout  wire sda,
    input  wire nack_mode
);
    timeunit 1ns;
    timeprecision 100ps;
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } model_state_e;

    model_state_e state;
    logic [7:0]   mem [0:2047];
    logic [7:0]   shift;
    logic [3:0]   bit_cnt;
    logic [2:0]   block;     // from the control byte of the write phase
    logic [7:0]   word;
    logic         ack_slot;
    logic         acked;
    logic         drive_low;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        logic [10:0] a;
        for (int i = 0; i < 2048; i++)
        begin
            a = 11'(i);
            mem[i] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
        end
        state     = M_IDLE;
        drive_low = 1'b0;
        bit_cnt   = 4'd0;
        ack_slot  = 1'b0;
    end

    // start and stop, sda moving while scl high
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_CTRL;
            bit_cnt   = 4'd0;
            ack_slot  = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_IDLE;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state == M_RDATA)
        begin
            shift   = shift << 1;
            bit_cnt = bit_cnt + 4'd1;
        end
        else if (state != M_IDLE && !ack_slot && bit_cnt < 4'd8)
        begin
            shift   = {shift[6:0], (sda !== 1'b0)};
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    // all sda changes happen a little after scl falls
    always @(negedge scl)
    begin
        logic nxt_low;
        #2;
        nxt_low = 1'b0;
        if (state == M_RDATA)
            nxt_low = (bit_cnt < 4'd8) ? ~shift[7] : 1'b0;
        else if (state != M_IDLE && ack_slot)
        begin
            ack_slot = 1'b0;
            bit_cnt  = 4'd0;
            if (!acked)
                state = M_IDLE;
            else if (state == M_CTRL && shift[0])
            begin
                state   = M_RDATA;
                shift   = mem[{shift[3:1], word}];  // block bits of the read control byte
                nxt_low = ~shift[7];
            end
            else if (state == M_CTRL)
            begin
                block = shift[3:1];
                state = M_ADDR;
            end
            else if (state == M_ADDR)
            begin
                word  = shift;
                state = M_WDATA;
            end
            else
            begin
                mem[{block, word}] = shift;  // write completes at once
                state = M_IDLE;
            end
        end
        else if (state != M_IDLE && bit_cnt == 4'd8)
        begin
            acked    = !nack_mode && (state != M_CTRL || shift[7:4] == CTRL_DEVICE_CODE);
            nxt_low  = acked;
            ack_slot = 1'b1;
        end
        drive_low = nxt_low;
    end

endmodule

`default_nettype wire

/* eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // 24C16 type code, upper nibble of the control byte
    localparam logic [3:0] CTRL_DEVICE_CODE = 4'b1010;

    typedef struct packed {
        logic        write;   // 0 selects a random read
        logic [10:0] addr;    // bits 10..8 go out in the control byte
        logic [7:0]  wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;     // some master byte was not acknowledged
    } eeprom_rsp_t;

    typedef enum logic [1:0] {
        OP_START,             // also used for repeated start
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bit_op_e;

    typedef struct packed {
        bit_op_e    op;
        logic [7:0] data;
        logic       master_ack;  // level driven in the ack slot of a read, 1 = nack
    } bit_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       ack;      // low when acknowledged
    } bit_rsp_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_DONE
    } seq_state_e;

endpackage

`default_nettype wire

/* eeprom_sequencer.sv */
`default_nettype none

module eeprom_sequencer (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     grant_valid,
    output logic                     grant_ready,
    input  eeprom_pkg::eeprom_req_t  grant_req,
    output logic                     done,
    output eeprom_pkg::eeprom_rsp_t  done_rsp,
    output logic                     cmd_valid,
    input  logic                     cmd_ready,
    output eeprom_pkg::bit_cmd_t     cmd,
    input  logic                     res_valid,
    input  eeprom_pkg::bit_rsp_t     res
);
    import eeprom_pkg::*;

    seq_state_e  state;
    seq_state_e  state_next;
    eeprom_req_t req_q;
    logic        issued;     // command handed to the engine, waiting for res
    logic        nack;
    logic [7:0]  rdata;
    logic        accept;

    assign accept = grant_valid && grant_ready;

    always_comb
    begin
        state_next = state;
        case (state)
            S_IDLE:
                if (accept)
                    state_next = S_START;
            S_START:
                if (res_valid)
                    state_next = S_CTRL_W;
            S_CTRL_W:
                if (res_valid)
                    state_next = res.ack ? S_STOP : S_ADDR;
            S_ADDR:
                if (res_valid)
                begin
                    if (res.ack)
                        state_next = S_STOP;
                    else
                        state_next = req_q.write ? S_DATA_W : S_RESTART;
                end
            S_DATA_W:
                if (res_valid)
                    state_next = S_STOP;
            S_RESTART:
                if (res_valid)
                    state_next = S_CTRL_R;
            S_CTRL_R:
                if (res_valid)
                    state_next = res.ack ? S_STOP : S_DATA_R;
            S_DATA_R:
                if (res_valid)
                    state_next = S_STOP;
            S_STOP:
                if (res_valid)
                    state_next = S_DONE;
            default:
                state_next = S_IDLE;   // S_DONE lasts one cycle
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= S_IDLE;
            issued      <= 1'b0;
            grant_ready <= 1'b0;
        end
        else
        begin
            state       <= state_next;
            grant_ready <= (state_next == S_IDLE);
            if (res_valid)
                issued <= 1'b0;
            else if (cmd_valid && cmd_ready)
                issued <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_q <= grant_req;
            nack  <= 1'b0;
            rdata <= 8'h00;
        end
        if (res_valid)
        begin
            // master sent bytes only, the read ack slot is our own nack
            if (res.ack && (state inside {S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R}))
                nack <= 1'b1;
            if (state == S_DATA_R)
                rdata <= res.data;
        end
    end

    assign cmd_valid = (state != S_IDLE) && (state != S_DONE) && !issued;

    always_comb
    begin
        cmd.op         = OP_WRITE;
        cmd.data       = 8'h00;
        cmd.master_ack = 1'b1;      // nack after the single read byte
        case (state)
            S_START, S_RESTART:
                cmd.op = OP_START;
            S_CTRL_W:
                cmd.data = {CTRL_DEVICE_CODE, req_q.addr[10:8], 1'b0};
            S_ADDR:
                cmd.data = req_q.addr[7:0];
            S_DATA_W:
                cmd.data = req_q.wdata;
            S_CTRL_R:
                cmd.data = {CTRL_DEVICE_CODE, req_q.addr[10:8], 1'b1};
            S_DATA_R:
                cmd.op = OP_READ;
            S_STOP:
                cmd.op = OP_STOP;
            default:
                cmd.op = OP_WRITE;
        endcase
    end

    assign done           = (state == S_DONE);
    assign done_rsp.rdata = rdata;
    assign done_rsp.nack  = nack;

endmodule

`default_nettype wire

/* i2c_bit_engine.sv */
`default_nettype none

module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  eeprom_pkg::bit_cmd_t  cmd,
    output logic                  res_valid,
    output eeprom_pkg::bit_rsp_t  res,
    output logic                  scl,
    output logic                  sda_drive_low,
    input  logic                  sda_in
);
    import eeprom_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic {
        ENG_IDLE,
        ENG_BUSY
    } eng_state_e;

    eng_state_e       state;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       phase;     // quarter within the scl period
    logic [3:0]       bit_cnt;
    logic [3:0]       last_bit;
    bit_cmd_t         cur;
    logic [7:0]       shift;
    logic             smp;
    logic             sda_sync;
    logic             tick;
    logic             accept;
    logic             last_tick;
    logic             lvl_scl;
    logic             lvl_low;

    assign cmd_ready = (state == ENG_IDLE);
    assign accept    = cmd_valid && cmd_ready;
    assign tick      = (state == ENG_BUSY) && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_tick = tick && (phase == 2'd3) && (bit_cnt == last_bit);

    always_comb
    begin
        case (cur.op)
            OP_START: last_bit = 4'd1;   // period 0 only for a repeated start
            OP_STOP:  last_bit = 4'd0;
            default:  last_bit = 4'd8;   // 8 data bits + ack
        endcase
    end

    // bus levels for the current quarter
    always_comb
    begin
        lvl_scl = (phase == 2'd1) || (phase == 2'd2);
        lvl_low = 1'b0;
        case (cur.op)
            OP_START:
            begin
                if (bit_cnt == 4'd0)
                    lvl_scl = (phase != 2'd0);   // free sda, then raise scl
                else
                begin
                    lvl_scl = (phase != 2'd3);
                    lvl_low = (phase != 2'd0);   // sda falls with scl high
                end
            end
            OP_STOP:
            begin
                lvl_scl = (phase != 2'd0);
                lvl_low = (phase < 2'd2);
            end
            OP_WRITE:
                lvl_low = (bit_cnt < 4'd8) ? ~shift[7] : 1'b0;
            default:
                lvl_low = (bit_cnt == 4'd8) ? ~cur.master_ack : 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= ENG_IDLE;
            res_valid     <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            div_cnt       <= '0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
        end
        else
        begin
            res_valid <= last_tick;
            if (state == ENG_BUSY)
            begin
                scl           <= lvl_scl;
                sda_drive_low <= lvl_low;
                div_cnt       <= tick ? '0 : div_cnt + 1'b1;
            end
            if (accept)
            begin
                state   <= ENG_BUSY;
                div_cnt <= '0;
                phase   <= 2'd0;
                // fresh start skips the release period when scl is already high
                bit_cnt <= (cmd.op == OP_START && scl) ? 4'd1 : 4'd0;
            end
            else if (tick)
            begin
                phase <= phase + 2'd1;
                if (last_tick)
                    state <= ENG_IDLE;
                else if (phase == 2'd3)
                    bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        sda_sync <= sda_in;
        if (accept)
        begin
            cur   <= cmd;
            shift <= cmd.data;
        end
        if (tick && phase == 2'd1)
            smp <= sda_sync;                  // middle of scl high
        if (tick && phase == 2'd3 && bit_cnt < 4'd8)
            shift <= {shift[6:0], smp};
        if (last_tick)
        begin
            res.data <= shift;
            res.ack  <= smp;
        end
    end

endmodule

`default_nettype wire

/* request_arbiter.sv */
`default_nettype none

module request_arbiter #(
    parameter int NUM_CLIENTS = 2
) (
    input  logic                                       CLK,
    input  logic                                       RESET,
    input  logic [NUM_CLIENTS-1:0]                     req_valid,
    output logic [NUM_CLIENTS-1:0]                     req_ready,
    input  eeprom_pkg::eeprom_req_t [NUM_CLIENTS-1:0]  req,
    output logic [NUM_CLIENTS-1:0]                     rsp_valid,
    output eeprom_pkg::eeprom_rsp_t [NUM_CLIENTS-1:0]  rsp,
    output logic                                       grant_valid,
    input  logic                                       grant_ready,
    output eeprom_pkg::eeprom_req_t                    grant_req,
    input  logic                                       done,
    input  eeprom_pkg::eeprom_rsp_t                    done_rsp
);
    localparam int IDX_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

    logic             busy;
    logic [IDX_W-1:0] lock_idx;
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] sel_idx;
    logic             sel_found;

    // first valid client at or after the pointer
    always_comb
    begin
        int cand;
        sel_found = 1'b0;
        sel_idx   = rr_ptr;
        for (int k = 0; k < NUM_CLIENTS; k++)
        begin
            cand = int'(rr_ptr) + k;
            if (cand >= NUM_CLIENTS)
                cand = cand - NUM_CLIENTS;
            if (!sel_found && req_valid[cand])
            begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(cand);
            end
        end
    end

    assign grant_valid = !busy && sel_found;
    assign grant_req   = req[sel_idx];

    always_comb
    begin
        for (int i = 0; i < NUM_CLIENTS; i++)
        begin
            req_ready[i] = grant_valid && grant_ready && (sel_idx == IDX_W'(i));
            rsp_valid[i] = done && busy && (lock_idx == IDX_W'(i));
            rsp[i]       = (lock_idx == IDX_W'(i)) ? done_rsp : '0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            lock_idx <= '0;
            rr_ptr   <= '0;
        end
        else if (grant_valid && grant_ready)
        begin
            busy     <= 1'b1;
            lock_idx <= sel_idx;
        end
        else if (done && busy)
        begin
            busy   <= 1'b0;
            rr_ptr <= (lock_idx == IDX_W'(NUM_CLIENTS - 1)) ? '0 : lock_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb_eeprom_ctrl.sv */
`default_nettype none

module tb_eeprom_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import eeprom_pkg::*;

    localparam int TIMEOUT = 5000;

    typedef struct packed {
        logic        client;
        logic        grp;    // runs concurrently with its grp neighbours
        logic        nack;   // model refuses every ack
        eeprom_req_t req;
        eeprom_rsp_t exp;
    } entry_t;

    logic              CLK;
    logic              RESET;
    logic [1:0]        req_valid;
    logic [1:0]        req_ready;
    eeprom_req_t [1:0] req;
    logic [1:0]        rsp_valid;
    eeprom_rsp_t [1:0] rsp;
    logic              scl;
    logic              sda_drive_low;
    logic              nack_mode;
    wire               sda;

    logic [1:0]  outstanding;
    logic [15:0] lfsr;
    logic [7:0]  shadow [0:2047];
    entry_t      tbl [$];
    logic        order [$];   // clients in order of completion

    pullup (sda);
    assign sda = sda_drive_low ? 1'b0 : 1'bz;

    eeprom_ctrl_top #(
        .CLK_DIV     (4),
        .NUM_CLIENTS (2)
    ) uut (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

    eeprom_model mem_model (
        .scl       (scl),
        .sda       (sda),
        .nack_mode (nack_mode)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #4 CLK = ~CLK;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    task automatic add_entry(input logic client, input logic grp, input logic write,
                             input logic [10:0] addr, input logic [7:0] data,
                             input logic nack);
        entry_t e;
        e.client    = client;
        e.grp       = grp;
        e.nack      = nack;
        e.req.write = write;
        e.req.addr  = addr;
        e.req.wdata = data;
        e.exp.nack  = nack;
        e.exp.rdata = write ? 8'h00 : shadow[addr];
        if (write && !nack)
            shadow[addr] = data;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        logic [10:0] a;
        logic [10:0] b;
        logic [7:0]  lo;
        logic [7:0]  d;
        logic [7:0]  d2;
        for (int i = 0; i < 2048; i++)
            shadow[i] = fill_byte(11'(i));
        lfsr = 16'd34;
        a = 11'(rand_bits(11));
        d = 8'(rand_bits(8));
        add_entry(1'b0, 1'b0, 1'b1, a, d, 1'b0);
        add_entry(1'b0, 1'b0, 1'b0, a, 8'h00, 1'b0);
        // same low byte in different blocks
        lo = 8'(rand_bits(8));
        d  = 8'(rand_bits(8));
        add_entry(1'b1, 1'b0, 1'b1, {3'd1, lo}, d, 1'b0);
        add_entry(1'b1, 1'b0, 1'b1, {3'd5, lo}, ~d, 1'b0);
        add_entry(1'b0, 1'b0, 1'b1, {3'd6, lo}, d ^ 8'h5a, 1'b0);
        add_entry(1'b0, 1'b0, 1'b0, {3'd1, lo}, 8'h00, 1'b0);
        add_entry(1'b1, 1'b0, 1'b0, {3'd5, lo}, 8'h00, 1'b0);
        add_entry(1'b0, 1'b0, 1'b0, {3'd6, lo}, 8'h00, 1'b0);
        add_entry(1'b1, 1'b0, 1'b0, {3'd2, lo}, 8'h00, 1'b0);  // never written
        b  = 11'(rand_bits(11));
        d  = 8'(rand_bits(8));
        d2 = 8'(rand_bits(8));
        add_entry(1'b0, 1'b1, 1'b1, b, d, 1'b0);
        add_entry(1'b1, 1'b1, 1'b1, b ^ 11'h400, d2, 1'b0);
        add_entry(1'b0, 1'b1, 1'b0, b, 8'h00, 1'b0);
        add_entry(1'b1, 1'b1, 1'b0, b ^ 11'h400, 8'h00, 1'b0);
        d = 8'(rand_bits(8));
        add_entry(1'b0, 1'b0, 1'b1, a, d, 1'b1);
        add_entry(1'b1, 1'b0, 1'b0, a, 8'h00, 1'b1);
        add_entry(1'b1, 1'b0, 1'b0, a, 8'h00, 1'b0);
    endtask

    task automatic check_rsp(input logic c, input eeprom_rsp_t got, input eeprom_rsp_t exp,
                             input logic is_read);
        if (got.nack !== exp.nack)
            abort_run($sformatf("** Error at %0d ns: client %0d nack %b, expected %b",
                                $time, c, got.nack, exp.nack));
        if (is_read && !exp.nack && got.rdata !== exp.rdata)
            abort_run($sformatf("** Error at %0d ns: client %0d rdata %h, expected %h",
                                $time, c, got.rdata, exp.rdata));
    endtask

    task automatic check_idle(input logic got_scl, input logic got_low,
                              input logic [1:0] got_rsp_valid);
        if (got_scl !== 1'b1 || got_low !== 1'b0 || got_rsp_valid !== 2'b00)
            abort_run($sformatf("** Error at %0d ns: scl %b sda_drive_low %b rsp_valid %b, %s",
                                $time, got_scl, got_low, got_rsp_valid, "expected idle bus"));
    endtask

    // entered 1 ns after a rising edge, left 1 ns after one
    task automatic issue(input int idx);
        entry_t e;
        int     n;
        e = tbl[idx];
        nack_mode             = e.nack;
        req[e.client]         = e.req;
        req_valid[e.client]   = 1'b1;
        outstanding[e.client] = 1'b1;
        n = 0;
        @(negedge CLK);
        while (!req_ready[e.client])
        begin
            if (n == TIMEOUT)
                abort_run($sformatf("client %0d never got req_ready within %0d cycles",
                                    e.client, TIMEOUT));
            n++;
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        req_valid[e.client] = 1'b0;
        n = 0;
        @(negedge CLK);
        while (!rsp_valid[e.client])
        begin
            if (n == TIMEOUT)
                abort_run($sformatf("client %0d never got rsp_valid within %0d cycles",
                                    e.client, TIMEOUT));
            n++;
            @(negedge CLK);
        end
        check_rsp(e.client, rsp[e.client], e.exp, !e.req.write);
        order.push_back(e.client);
        @(posedge CLK);
        #1;
        outstanding[e.client] = 1'b0;
    endtask

    task automatic run_client(input logic c, input int first, input int last);
        for (int k = first; k < last; k++)
            if (tbl[k].client == c)
                issue(k);
    endtask

    // a response pulse must land on the client that asked
    always @(negedge CLK)
    begin
        for (int c = 0; c < 2; c++)
            if (rsp_valid[c] === 1'b1 && !outstanding[c])
                abort_run($sformatf("response on client %0d with no request pending", c));
    end

    initial
    begin
        int i;
        int j;
        RESET       = 1'b1;
        req_valid   = '0;
        req         = '0;
        nack_mode   = 1'b0;
        outstanding = '0;
        build_table();
        repeat (8) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        check_idle(scl, sda_drive_low, rsp_valid);
        @(posedge CLK);
        #1;
        i = 0;
        while (i < tbl.size())
        begin
            if (tbl[i].grp)
            begin
                j = i;
                while (j < tbl.size() && tbl[j].grp)
                    j++;
                order.delete();
                fork
                    run_client(1'b0, i, j);
                    run_client(1'b1, i, j);
                join
                for (int k = 1; k < order.size(); k++)
                    if (order[k] == order[k-1])
                        abort_run($sformatf("client %0d was served twice in a row", order[k]));
                i = j;
            end
            else
            begin
                issue(i);
                i++;
            end
            check_idle(scl, sda_drive_low, rsp_valid);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
